//--- common/rou_pkg.sv
`default_nettype none

package rou_pkg;

  // Datapath and register file
  localparam int XLEN = 32;
  localparam int PREG_NUM = 32;
  localparam int PLEN = 5;
  localparam int RLEN = 5;

  // Queue and reorder buffer sizes
  localparam int UOQ_SIZE = 4;
  localparam int UOQ_PTR_LEN = $clog2(UOQ_SIZE);
  localparam int ROB_SIZE = 8;
  localparam int ROB_TAG_LEN = 3;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [PLEN-1:0] preg_t;
  typedef logic [RLEN-1:0] areg_t;
  typedef logic [ROB_TAG_LEN-1:0] rob_tag_t;

  // ALU_BEQ is the only branch, everything else falls through to pc + 4
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SLT = 3'd6,
    ALU_BEQ = 3'd7
  } alu_op_t;

  typedef enum logic [1:0] {
    ROB_FREE = 2'd0,
    ROB_EXEC = 2'd1,
    ROB_DONE = 2'd2
  } rob_state_t;

endpackage

`default_nettype wire

//--- verilog/phys_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module phys_regfile (
  input  logic           clock,
  input  logic           rst,
  input  rou_pkg::preg_t rd_addr1,
  input  rou_pkg::preg_t rd_addr2,
  output rou_pkg::word_t rd_data1,
  output rou_pkg::word_t rd_data2,
  output logic           rd_ready1,
  output logic           rd_ready2,
  input  logic           alloc_en,
  input  rou_pkg::preg_t alloc_prd,
  input  logic           wb_valid,
  input  rou_pkg::preg_t wb_prd,
  input  rou_pkg::word_t wb_result,
  input  logic           flush
);
  import rou_pkg::*;

  word_t               regs [PREG_NUM];
  logic [PREG_NUM-1:0] ready;

  // Register zero is never written
  always_ff @(posedge clock) begin
    if (wb_valid && wb_prd != '0)
      regs[wb_prd] <= wb_result;
  end

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      ready <= '1;
    end else begin
      if (wb_valid)
        ready[wb_prd] <= 1'b1;
      // A fresh allocation wins over a late writeback to the same register
      if (alloc_en && alloc_prd != '0)
        ready[alloc_prd] <= 1'b0;
    end
  end

  always_comb begin
    rd_data1  = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    rd_ready1 = (rd_addr1 == '0) || ready[rd_addr1];
    rd_data2  = (rd_addr2 == '0) ? '0 : regs[rd_addr2];
    rd_ready2 = (rd_addr2 == '0) || ready[rd_addr2];
  end

endmodule

`default_nettype wire

//--- verilog/dispatch_queue.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_queue (
  input  logic              clock,
  input  logic              rst,
  input  logic              flush,
  input  logic              in_valid,
  input  rou_pkg::word_t    in_pc,
  input  rou_pkg::word_t    in_pnpc,
  input  rou_pkg::alu_op_t  in_op,
  input  rou_pkg::areg_t    in_rd,
  input  rou_pkg::preg_t    in_prd,
  input  rou_pkg::preg_t    in_pr1,
  input  rou_pkg::preg_t    in_pr2,
  input  rou_pkg::word_t    in_imm1,
  input  rou_pkg::word_t    in_imm2,
  output logic              in_ready,
  output rou_pkg::preg_t    rf_addr1,
  output rou_pkg::preg_t    rf_addr2,
  input  rou_pkg::word_t    rf_data1,
  input  rou_pkg::word_t    rf_data2,
  input  logic              rf_ready1,
  input  logic              rf_ready2,
  input  logic              wb_valid,
  input  rou_pkg::preg_t    wb_prd,
  input  rou_pkg::word_t    wb_result,
  input  logic              alloc_ready,
  input  rou_pkg::rob_tag_t alloc_tag,
  output logic              iss_valid,
  output rou_pkg::alu_op_t  iss_op,
  output rou_pkg::word_t    iss_a,
  output rou_pkg::word_t    iss_b,
  output rou_pkg::word_t    iss_pc,
  output rou_pkg::preg_t    iss_prd,
  output rou_pkg::rob_tag_t iss_tag,
  output rou_pkg::word_t    alloc_pc,
  output rou_pkg::word_t    alloc_pnpc,
  output rou_pkg::areg_t    alloc_rd,
  output rou_pkg::preg_t    alloc_prd
);
  import rou_pkg::*;

  logic [UOQ_PTR_LEN-1:0] head;
  logic [UOQ_PTR_LEN-1:0] tail;
  logic [UOQ_SIZE-1:0]    slot_valid;

  word_t   uoq_pc   [UOQ_SIZE];
  word_t   uoq_pnpc [UOQ_SIZE];
  alu_op_t uoq_op   [UOQ_SIZE];
  areg_t   uoq_rd   [UOQ_SIZE];
  preg_t   uoq_prd  [UOQ_SIZE];
  preg_t   uoq_pr1  [UOQ_SIZE];
  preg_t   uoq_pr2  [UOQ_SIZE];
  word_t   uoq_imm1 [UOQ_SIZE];
  word_t   uoq_imm2 [UOQ_SIZE];

  logic in_fire;
  logic src1_ok;
  logic src2_ok;

  // Immediate first, then register file, then the writeback bypass
  function automatic word_t pick_operand(input preg_t pr, input word_t imm,
                                         input word_t rf_data, input logic rf_rdy,
                                         input word_t bypass);
    word_t val;
    if (pr == '0)
      val = imm;
    else if (rf_rdy)
      val = rf_data;
    else
      val = bypass;
    return val;
  endfunction

  assign in_ready = !slot_valid[tail];
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clock) begin
    if (in_fire) begin
      uoq_pc[tail]   <= in_pc;
      uoq_pnpc[tail] <= in_pnpc;
      uoq_op[tail]   <= in_op;
      uoq_rd[tail]   <= in_rd;
      uoq_prd[tail]  <= in_prd;
      uoq_pr1[tail]  <= in_pr1;
      uoq_pr2[tail]  <= in_pr2;
      uoq_imm1[tail] <= in_imm1;
      uoq_imm2[tail] <= in_imm2;
    end
  end

  // Head operands come straight from the register file read ports
  assign rf_addr1 = uoq_pr1[head];
  assign rf_addr2 = uoq_pr2[head];

  assign src1_ok = (uoq_pr1[head] == '0) || rf_ready1 || (wb_valid && wb_prd == uoq_pr1[head]);
  assign src2_ok = (uoq_pr2[head] == '0) || rf_ready2 || (wb_valid && wb_prd == uoq_pr2[head]);

  // ALU pipe never stalls, so only the ROB can hold the head
  assign iss_valid = slot_valid[head] && src1_ok && src2_ok && alloc_ready;

  assign iss_op  = uoq_op[head];
  assign iss_a   = pick_operand(uoq_pr1[head], uoq_imm1[head], rf_data1, rf_ready1, wb_result);
  assign iss_b   = pick_operand(uoq_pr2[head], uoq_imm2[head], rf_data2, rf_ready2, wb_result);
  assign iss_pc  = uoq_pc[head];
  assign iss_prd = uoq_prd[head];
  assign iss_tag = alloc_tag;

  assign alloc_pc   = uoq_pc[head];
  assign alloc_pnpc = uoq_pnpc[head];
  assign alloc_rd   = uoq_rd[head];
  assign alloc_prd  = uoq_prd[head];

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      head       <= '0;
      tail       <= '0;
      slot_valid <= '0;
    end else begin
      if (in_fire) begin
        slot_valid[tail] <= 1'b1;
        tail             <= tail + 1'b1;
      end
      if (iss_valid) begin
        slot_valid[head] <= 1'b0;
        head             <= head + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- exec/alu_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module alu_pipe (
  input  logic              clock,
  input  logic              rst,
  input  logic              flush,
  input  logic              iss_valid,
  input  rou_pkg::alu_op_t  iss_op,
  input  rou_pkg::word_t    iss_a,
  input  rou_pkg::word_t    iss_b,
  input  rou_pkg::word_t    iss_pc,
  input  rou_pkg::preg_t    iss_prd,
  input  rou_pkg::rob_tag_t iss_tag,
  output logic              wb_valid,
  output rou_pkg::rob_tag_t wb_tag,
  output rou_pkg::preg_t    wb_prd,
  output rou_pkg::word_t    wb_result,
  output rou_pkg::word_t    wb_npc
);
  import rou_pkg::*;

  word_t    result_d;
  logic     taken_d;

  logic     s1_valid;
  rob_tag_t s1_tag;
  preg_t    s1_prd;
  word_t    s1_pc;
  word_t    s1_offset;
  word_t    s1_result;
  logic     s1_taken;

  logic     s2_valid;
  rob_tag_t s2_tag;
  preg_t    s2_prd;
  word_t    s2_result;
  word_t    s2_npc;

  always_comb begin
    taken_d = 1'b0;
    case (iss_op)
      ALU_ADD: result_d = iss_a + iss_b;
      ALU_SUB: result_d = iss_a - iss_b;
      ALU_AND: result_d = iss_a & iss_b;
      ALU_OR:  result_d = iss_a | iss_b;
      ALU_XOR: result_d = iss_a ^ iss_b;
      ALU_SLL: result_d = iss_a << iss_b[4:0];
      ALU_SLT: result_d = {{(XLEN-1){1'b0}}, $signed(iss_a) < $signed(iss_b)};
      // Branch writes zero, op2 doubles as the target offset
      ALU_BEQ: begin
        result_d = '0;
        taken_d  = (iss_a == iss_b);
      end
      default: result_d = '0;
    endcase
  end

  // Stage 1
  always_ff @(posedge clock) begin
    s1_tag    <= iss_tag;
    s1_prd    <= iss_prd;
    s1_pc     <= iss_pc;
    s1_offset <= iss_b;
    s1_result <= result_d;
    s1_taken  <= taken_d;
  end

  // Stage 2, next pc
  always_ff @(posedge clock) begin
    s2_tag    <= s1_tag;
    s2_prd    <= s1_prd;
    s2_result <= s1_result;
    s2_npc    <= s1_taken ? s1_pc + s1_offset : s1_pc + 32'd4;
  end

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= iss_valid;
      s2_valid <= s1_valid;
    end
  end

  assign wb_valid  = s2_valid;
  assign wb_tag    = s2_tag;
  assign wb_prd    = s2_prd;
  assign wb_result = s2_result;
  assign wb_npc    = s2_npc;

endmodule

`default_nettype wire

//--- rob/reorder_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
  input  logic              clock,
  input  logic              rst,
  input  logic              alloc_valid,
  output logic              alloc_ready,
  output rou_pkg::rob_tag_t alloc_tag,
  input  rou_pkg::word_t    alloc_pc,
  input  rou_pkg::word_t    alloc_pnpc,
  input  rou_pkg::areg_t    alloc_rd,
  input  rou_pkg::preg_t    alloc_prd,
  input  logic              wb_valid,
  input  rou_pkg::rob_tag_t wb_tag,
  input  rou_pkg::word_t    wb_result,
  input  rou_pkg::word_t    wb_npc,
  input  logic              commit_ready,
  output logic              commit_valid,
  output rou_pkg::word_t    commit_pc,
  output rou_pkg::areg_t    commit_rd,
  output rou_pkg::preg_t    commit_prd,
  output rou_pkg::word_t    commit_result,
  output logic              commit_flush,
  output logic              flush
);
  import rou_pkg::*;

  rob_state_t rob_state  [ROB_SIZE];
  word_t      rob_pc     [ROB_SIZE];
  word_t      rob_pnpc   [ROB_SIZE];
  areg_t      rob_rd     [ROB_SIZE];
  preg_t      rob_prd    [ROB_SIZE];
  word_t      rob_result [ROB_SIZE];
  word_t      rob_npc    [ROB_SIZE];

  rob_tag_t head;
  rob_tag_t tail;

  logic alloc_fire;
  logic commit_fire;
  logic mispredict;

  // Entry at the tail must be free before it can be handed out
  assign alloc_ready = (rob_state[tail] == ROB_FREE);
  assign alloc_tag   = tail;
  assign alloc_fire  = alloc_valid && alloc_ready;

  always_ff @(posedge clock) begin
    if (alloc_fire) begin
      rob_pc[tail]   <= alloc_pc;
      rob_pnpc[tail] <= alloc_pnpc;
      rob_rd[tail]   <= alloc_rd;
      rob_prd[tail]  <= alloc_prd;
    end
    if (wb_valid) begin
      rob_result[wb_tag] <= wb_result;
      rob_npc[wb_tag]    <= wb_npc;
    end
  end

  // Head retires once its result is back
  assign commit_valid  = (rob_state[head] == ROB_DONE);
  assign commit_pc     = rob_pc[head];
  assign commit_rd     = rob_rd[head];
  assign commit_prd    = rob_prd[head];
  assign commit_result = rob_result[head];

  assign mispredict   = (rob_npc[head] != rob_pnpc[head]);
  assign commit_flush = commit_valid && mispredict;
  assign commit_fire  = commit_valid && commit_ready;

  // Everything behind a mispredicted head is wrong path
  assign flush = commit_fire && mispredict;

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < ROB_SIZE; i++) begin
        rob_state[i] <= ROB_FREE;
      end
    end else begin
      if (alloc_fire) begin
        rob_state[tail] <= ROB_EXEC;
        tail            <= tail + 1'b1;
      end
      // Tag always points at an entry in ROB_EXEC, never the tail or a done head
      if (wb_valid)
        rob_state[wb_tag] <= ROB_DONE;
      if (commit_fire) begin
        rob_state[head] <= ROB_FREE;
        head            <= head + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/backend_top.sv
`timescale 1ns/10ps
`default_nettype none

module backend_top (
  input  logic             clock,
  input  logic             rst,
  input  logic             in_valid,
  input  rou_pkg::word_t   in_pc,
  input  rou_pkg::word_t   in_pnpc,
  input  rou_pkg::alu_op_t in_op,
  input  rou_pkg::areg_t   in_rd,
  input  rou_pkg::preg_t   in_prd,
  input  rou_pkg::preg_t   in_pr1,
  input  rou_pkg::preg_t   in_pr2,
  input  rou_pkg::word_t   in_imm1,
  input  rou_pkg::word_t   in_imm2,
  output logic             in_ready,
  input  logic             commit_ready,
  output logic             commit_valid,
  output rou_pkg::word_t   commit_pc,
  output rou_pkg::areg_t   commit_rd,
  output rou_pkg::preg_t   commit_prd,
  output rou_pkg::word_t   commit_result,
  output logic             commit_flush
);
  import rou_pkg::*;

  logic     in_fire;
  logic     flush;

  preg_t    rf_addr1;
  preg_t    rf_addr2;
  word_t    rf_data1;
  word_t    rf_data2;
  logic     rf_ready1;
  logic     rf_ready2;

  logic     alloc_ready;
  rob_tag_t alloc_tag;
  word_t    alloc_pc;
  word_t    alloc_pnpc;
  areg_t    alloc_rd;
  preg_t    alloc_prd;

  logic     iss_valid;
  alu_op_t  iss_op;
  word_t    iss_a;
  word_t    iss_b;
  word_t    iss_pc;
  preg_t    iss_prd;
  rob_tag_t iss_tag;

  logic     wb_valid;
  rob_tag_t wb_tag;
  preg_t    wb_prd;
  word_t    wb_result;
  word_t    wb_npc;

  // Destination goes busy as soon as the queue takes the micro-op
  assign in_fire = in_valid && in_ready;

  phys_regfile u_regfile (
    .clock     (clock),
    .rst       (rst),
    .rd_addr1  (rf_addr1),
    .rd_addr2  (rf_addr2),
    .rd_data1  (rf_data1),
    .rd_data2  (rf_data2),
    .rd_ready1 (rf_ready1),
    .rd_ready2 (rf_ready2),
    .alloc_en  (in_fire),
    .alloc_prd (in_prd),
    .wb_valid  (wb_valid),
    .wb_prd    (wb_prd),
    .wb_result (wb_result),
    .flush     (flush)
  );

  dispatch_queue u_queue (
    .clock       (clock),
    .rst         (rst),
    .flush       (flush),
    .in_valid    (in_valid),
    .in_pc       (in_pc),
    .in_pnpc     (in_pnpc),
    .in_op       (in_op),
    .in_rd       (in_rd),
    .in_prd      (in_prd),
    .in_pr1      (in_pr1),
    .in_pr2      (in_pr2),
    .in_imm1     (in_imm1),
    .in_imm2     (in_imm2),
    .in_ready    (in_ready),
    .rf_addr1    (rf_addr1),
    .rf_addr2    (rf_addr2),
    .rf_data1    (rf_data1),
    .rf_data2    (rf_data2),
    .rf_ready1   (rf_ready1),
    .rf_ready2   (rf_ready2),
    .wb_valid    (wb_valid),
    .wb_prd      (wb_prd),
    .wb_result   (wb_result),
    .alloc_ready (alloc_ready),
    .alloc_tag   (alloc_tag),
    .iss_valid   (iss_valid),
    .iss_op      (iss_op),
    .iss_a       (iss_a),
    .iss_b       (iss_b),
    .iss_pc      (iss_pc),
    .iss_prd     (iss_prd),
    .iss_tag     (iss_tag),
    .alloc_pc    (alloc_pc),
    .alloc_pnpc  (alloc_pnpc),
    .alloc_rd    (alloc_rd),
    .alloc_prd   (alloc_prd)
  );

  alu_pipe u_alu (
    .clock     (clock),
    .rst       (rst),
    .flush     (flush),
    .iss_valid (iss_valid),
    .iss_op    (iss_op),
    .iss_a     (iss_a),
    .iss_b     (iss_b),
    .iss_pc    (iss_pc),
    .iss_prd   (iss_prd),
    .iss_tag   (iss_tag),
    .wb_valid  (wb_valid),
    .wb_tag    (wb_tag),
    .wb_prd    (wb_prd),
    .wb_result (wb_result),
    .wb_npc    (wb_npc)
  );

  // Issue and allocation are the same transfer
  reorder_buffer u_rob (
    .clock         (clock),
    .rst           (rst),
    .alloc_valid   (iss_valid),
    .alloc_ready   (alloc_ready),
    .alloc_tag     (alloc_tag),
    .alloc_pc      (alloc_pc),
    .alloc_pnpc    (alloc_pnpc),
    .alloc_rd      (alloc_rd),
    .alloc_prd     (alloc_prd),
    .wb_valid      (wb_valid),
    .wb_tag        (wb_tag),
    .wb_result     (wb_result),
    .wb_npc        (wb_npc),
    .commit_ready  (commit_ready),
    .commit_valid  (commit_valid),
    .commit_pc     (commit_pc),
    .commit_rd     (commit_rd),
    .commit_prd    (commit_prd),
    .commit_result (commit_result),
    .commit_flush  (commit_flush),
    .flush         (flush)
  );

endmodule

`default_nettype wire

//--- sim/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic rst
);

  initial begin
    clock = 1'b0;
    rst   = 1'b1;
  end

  // 20 ns period
  always #10 clock = ~clock;

  initial begin
    repeat (16) @(posedge clock);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/tb_backend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_backend;
  import rou_pkg::*;

  localparam int NAREG = 8;

  typedef struct packed {
    word_t pc;
    word_t pnpc;
    word_t npc;
    areg_t rd;
    preg_t prd;
    word_t result;
    logic  flush;
  } exp_t;

  logic    clock;
  logic    rst;
  logic    in_valid;
  word_t   in_pc;
  word_t   in_pnpc;
  alu_op_t in_op;
  areg_t   in_rd;
  preg_t   in_prd;
  preg_t   in_pr1;
  preg_t   in_pr2;
  word_t   in_imm1;
  word_t   in_imm2;
  logic    in_ready;
  logic    commit_ready;
  logic    commit_valid;
  word_t   commit_pc;
  areg_t   commit_rd;
  preg_t   commit_prd;
  word_t   commit_result;
  logic    commit_flush;

  // Renamer state, speculative and committed
  preg_t spec_map [NAREG];
  word_t spec_val [NAREG];
  preg_t comm_map [NAREG];
  word_t comm_val [NAREG];
  word_t spec_pc;
  preg_t free_ptr;
  exp_t  exp_q [$];
  exp_t  pend;

  logic        in_accepted;
  logic        pend_stale;
  logic        saw_full;
  logic        rand_ready;
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          commits;
  int          flushes;
  int          issued;
  int          cycles;
  int          tests;

  clock_gen u_clk (
    .clock (clock),
    .rst   (rst)
  );

  backend_top uut (
    .clock         (clock),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_pc         (in_pc),
    .in_pnpc       (in_pnpc),
    .in_op         (in_op),
    .in_rd         (in_rd),
    .in_prd        (in_prd),
    .in_pr1        (in_pr1),
    .in_pr2        (in_pr2),
    .in_imm1       (in_imm1),
    .in_imm2       (in_imm2),
    .in_ready      (in_ready),
    .commit_ready  (commit_ready),
    .commit_valid  (commit_valid),
    .commit_pc     (commit_pc),
    .commit_rd     (commit_rd),
    .commit_prd    (commit_prd),
    .commit_result (commit_result),
    .commit_flush  (commit_flush)
  );

  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'd0, lcg_state[31:16]};
  endfunction

  function automatic word_t ref_alu(input alu_op_t op, input word_t a, input word_t b);
    word_t r;
    r = '0;
    if (op == ALU_ADD)
      r = a + b;
    else if (op == ALU_SUB)
      r = a + ~b + 32'd1;
    else if (op == ALU_AND)
      r = a & b;
    else if (op == ALU_OR)
      r = a | b;
    else if (op == ALU_XOR)
      r = a ^ b;
    else if (op == ALU_SLL)
      r = a << b[4:0];
    else if (op == ALU_SLT)
      r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    return r;
  endfunction

  function automatic logic preg_busy(input preg_t p);
    logic busy;
    busy = 1'b0;
    for (int i = 1; i < NAREG; i++) begin
      if (spec_map[i] == p || comm_map[i] == p)
        busy = 1'b1;
    end
    foreach (exp_q[j]) begin
      if (exp_q[j].prd == p)
        busy = 1'b1;
    end
    return busy;
  endfunction

  // Round robin over 1..31, skipping anything mapped or in flight
  function automatic preg_t alloc_preg();
    preg_t p;
    logic  found;
    p = free_ptr;
    found = 1'b0;
    for (int n = 0; n < PREG_NUM; n++) begin
      if (!found) begin
        p = (p == preg_t'(PREG_NUM - 1)) ? preg_t'(1) : p + preg_t'(1);
        found = !preg_busy(p);
      end
    end
    free_ptr = p;
    return p;
  endfunction

  function automatic word_t src_value(input areg_t s, input word_t imm);
    return (s == '0) ? imm : spec_val[s];
  endfunction

  task automatic check_val(input string name, input word_t expv, input word_t got);
    checks++;
    assert (expv === got) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, expv, got);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("%0t %s", $time, msg);
      errors++;
    end
  endtask

  // Unmapped sources go as immediates carrying their value
  task automatic build_pending(input alu_op_t op, input areg_t rd, input areg_t s1,
                               input areg_t s2, input word_t imm1, input word_t imm2,
                               input logic pred_taken);
    word_t a;
    word_t b;
    logic  taken;
    a = src_value(s1, imm1);
    b = src_value(s2, imm2);
    taken = (op == ALU_BEQ) && (a == b);
    pend.pc  = spec_pc;
    pend.npc = taken ? spec_pc + b : spec_pc + 32'd4;
    if (op == ALU_BEQ && pred_taken)
      pend.pnpc = spec_pc + b;
    else
      pend.pnpc = spec_pc + 32'd4;
    pend.rd     = (op == ALU_BEQ) ? areg_t'(0) : rd;
    pend.prd    = (pend.rd == '0) ? preg_t'(0) : alloc_preg();
    pend.result = ref_alu(op, a, b);
    pend.flush  = (pend.npc != pend.pnpc);
    in_pc   = pend.pc;
    in_pnpc = pend.pnpc;
    in_op   = op;
    in_rd   = pend.rd;
    in_prd  = pend.prd;
    in_pr1  = (s1 == '0) ? preg_t'(0) : spec_map[s1];
    in_pr2  = (s2 == '0) ? preg_t'(0) : spec_map[s2];
    in_imm1 = a;
    in_imm2 = b;
    in_valid = 1'b1;
  endtask

  task automatic send_uop(input alu_op_t op, input areg_t rd, input areg_t s1,
                          input areg_t s2, input word_t imm1, input word_t imm2,
                          input logic pred_taken);
    issued++;
    in_accepted = 1'b0;
    pend_stale = 1'b0;
    build_pending(op, rd, s1, s2, imm1, imm2, pred_taken);
    while (!in_accepted) begin
      @(posedge clock);
      #1;
      // A flush dropped or outdated the held micro-op
      if (!in_accepted && pend_stale) begin
        pend_stale = 1'b0;
        build_pending(op, rd, s1, s2, imm1, imm2, pred_taken);
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clock);
      #1;
    end
    repeat (4) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    if (errors == err0)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - err0);
  endtask

  always @(posedge clock) begin : monitor
    exp_t e;
    logic flushed;
    if (!rst) begin
      flushed = 1'b0;
      if (commit_valid && commit_ready) begin
        commits++;
        if (commit_flush)
          flushes++;
        check_true(exp_q.size() != 0, "commit seen with no micro-op outstanding");
        if (exp_q.size() != 0) begin
          e = exp_q.pop_front();
          check_val("commit_pc", e.pc, commit_pc);
          check_val("commit_rd", word_t'(e.rd), word_t'(commit_rd));
          check_val("commit_prd", word_t'(e.prd), word_t'(commit_prd));
          check_val("commit_result", e.result, commit_result);
          check_val("commit_flush", word_t'(e.flush), word_t'(commit_flush));
          if (e.rd != '0) begin
            comm_map[e.rd] = e.prd;
            comm_val[e.rd] = e.result;
          end
          if (e.flush) begin
            exp_q.delete();
            spec_map = comm_map;
            spec_val = comm_val;
            spec_pc = e.npc;
            flushed = 1'b1;
            pend_stale = 1'b1;
          end
        end
      end
      if (in_valid && in_ready && !flushed) begin
        exp_q.push_back(pend);
        if (pend.rd != '0) begin
          spec_map[pend.rd] = pend.prd;
          spec_val[pend.rd] = pend.result;
        end
        spec_pc = pend.pnpc;
        in_accepted = 1'b1;
      end
      if (in_valid && !in_ready)
        saw_full = 1'b1;
    end
  end

  // Draw on the edge, drive just after it
  always @(posedge clock) begin : ready_toggle
    logic draw;
    if (rand_ready) begin
      draw = (next_rand() % 4) != 0;
      #1;
      if (rand_ready)
        commit_ready = draw;
    end
  end

  // Budget grows with every micro-op sent
  always @(posedge clock) begin
    cycles++;
    if (cycles > 200 * issued + 1000) begin
      $display("Timeout after %0d cycles with %0d micro-ops sent", cycles, issued);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic test_reset();
    int err0;
    err0 = errors;
    check_val("commit_valid", 32'd0, word_t'(commit_valid));
    check_val("in_ready", 32'd1, word_t'(in_ready));
    report_test("reset", err0);
  endtask

  task automatic test_independent();
    int err0;
    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      send_uop(alu_op_t'(i % 7), areg_t'(1 + i % 7), 5'd0, 5'd0,
               32'h100 + 32'(i * 3), 32'(i + 2), 1'b0);
    end
    drain();
    report_test("independent", err0);
  endtask

  task automatic test_dependent();
    int err0;
    err0 = errors;
    send_uop(ALU_ADD, 5'd1, 5'd0, 5'd0, 32'd7, 32'd0, 1'b0);
    send_uop(ALU_ADD, 5'd2, 5'd1, 5'd0, 32'd0, 32'd5, 1'b0);
    send_uop(ALU_SUB, 5'd3, 5'd2, 5'd1, 32'd0, 32'd0, 1'b0);
    send_uop(ALU_XOR, 5'd4, 5'd3, 5'd2, 32'd0, 32'd0, 1'b0);
    send_uop(ALU_SLL, 5'd5, 5'd4, 5'd0, 32'd0, 32'd3, 1'b0);
    send_uop(ALU_SLT, 5'd6, 5'd5, 5'd1, 32'd0, 32'd0, 1'b0);
    // Gap so the later reads come from the register file
    repeat (8) begin
      @(posedge clock);
      #1;
    end
    send_uop(ALU_ADD, 5'd7, 5'd1, 5'd2, 32'd0, 32'd0, 1'b0);
    send_uop(ALU_AND, 5'd1, 5'd7, 5'd3, 32'd0, 32'd0, 1'b0);
    drain();
    report_test("dependent", err0);
  endtask

  task automatic test_backpressure();
    int err0;
    int c0;
    err0 = errors;
    c0 = commits;
    saw_full = 1'b0;
    fork
      begin
        for (int i = 0; i < 15; i++) begin
          send_uop(ALU_ADD, areg_t'(1 + i % 7), areg_t'(1 + (i + 6) % 7), 5'd0,
                   32'd0, 32'(i + 1), 1'b0);
        end
      end
      begin
        commit_ready = 1'b0;
        repeat (30) @(posedge clock);
        #1;
        commit_ready = 1'b1;
      end
    join
    drain();
    check_true(saw_full, "in_ready never fell while commits were held");
    check_true(commits - c0 == 15, "back-pressure run did not commit 15 micro-ops");
    report_test("backpressure", err0);
  endtask

  task automatic test_branch();
    int err0;
    int f0;
    err0 = errors;
    f0 = flushes;
    send_uop(ALU_ADD, 5'd1, 5'd0, 5'd0, 32'd16, 32'd0, 1'b0);
    // Taken but predicted not taken
    send_uop(ALU_BEQ, 5'd0, 5'd1, 5'd0, 32'd0, 32'd16, 1'b0);
    send_uop(ALU_ADD, 5'd2, 5'd1, 5'd0, 32'd0, 32'd1, 1'b0);
    send_uop(ALU_ADD, 5'd3, 5'd0, 5'd0, 32'd3, 32'd4, 1'b0);
    send_uop(ALU_OR, 5'd4, 5'd1, 5'd0, 32'd0, 32'd9, 1'b0);
    drain();
    check_true(flushes - f0 == 1, "mispredicted branch did not flush exactly once");
    send_uop(ALU_BEQ, 5'd0, 5'd1, 5'd0, 32'd0, 32'd16, 1'b1);
    send_uop(ALU_BEQ, 5'd0, 5'd1, 5'd0, 32'd0, 32'd12, 1'b0);
    send_uop(ALU_SUB, 5'd5, 5'd1, 5'd4, 32'd0, 32'd0, 1'b0);
    drain();
    check_true(flushes - f0 == 1, "correctly predicted branch raised a flush");
    report_test("branch", err0);
  endtask

  task automatic test_random();
    int      err0;
    word_t   r;
    alu_op_t op;
    areg_t   rd;
    areg_t   s1;
    areg_t   s2;
    word_t   imm1;
    word_t   imm2;
    logic    pred;
    err0 = errors;
    rand_ready = 1'b1;
    for (int i = 0; i < 200; i++) begin
      r = next_rand();
      op = alu_op_t'(r[2:0]);
      rd = areg_t'(1 + next_rand() % 7);
      s1 = areg_t'(next_rand() % 8);
      s2 = areg_t'(next_rand() % 8);
      imm1 = next_rand();
      imm2 = next_rand() % 64;
      r = next_rand();
      pred = r[0];
      if (op == ALU_BEQ) begin
        s2 = 5'd0;
        // Half the branches compare equal
        if (r[1])
          imm2 = src_value(s1, imm1);
        else
          imm2 = {imm2[29:0], 2'b00};
      end
      send_uop(op, rd, s1, s2, imm1, imm2, pred);
    end
    rand_ready = 1'b0;
    commit_ready = 1'b1;
    drain();
    report_test("random", err0);
  endtask

  initial begin
    in_valid = 1'b0;
    in_pc = '0;
    in_pnpc = '0;
    in_op = ALU_ADD;
    in_rd = '0;
    in_prd = '0;
    in_pr1 = '0;
    in_pr2 = '0;
    in_imm1 = '0;
    in_imm2 = '0;
    commit_ready = 1'b1;
    for (int i = 0; i < NAREG; i++) begin
      spec_map[i] = '0;
      spec_val[i] = '0;
      comm_map[i] = '0;
      comm_val[i] = '0;
    end
    spec_pc = 32'h1000;
    free_ptr = '0;
    in_accepted = 1'b0;
    pend_stale = 1'b0;
    saw_full = 1'b0;
    rand_ready = 1'b0;
    lcg_state = 32'd61;
    errors = 0;
    checks = 0;
    commits = 0;
    flushes = 0;
    issued = 0;
    cycles = 0;
    tests = 0;
    pend = '0;
    @(negedge rst);
    #1;
    test_reset();
    test_independent();
    test_dependent();
    test_backpressure();
    test_branch();
    test_random();
    $display("tests %0d, checks %0d, commits %0d, flushes %0d, errors %0d",
             tests, checks, commits, flushes, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
common/rou_pkg.sv
verilog/phys_regfile.sv
verilog/dispatch_queue.sv
exec/alu_pipe.sv
rob/reorder_buffer.sv
verilog/backend_top.sv
sim/clock_gen.sv
sim/tb_backend.sv

//--- Makefile
SIM      = verilator
TOP      = tb_backend
FILELIST = tb.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
PASS_MSG = Simulation completed successfully
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
